//--- source/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// pixel, weight, bias and result width
`define CNN_DWIDTH 16

// wide enough for nine 16x16 products
`define CNN_AWIDTH 36

`define CNN_KERN   3  // kernel edge
`define CNN_NPARAM 10 // nine weights, then bias
`define CNN_POOL   4  // results per pool group
`define CNN_QWIDTH 5  // requant shift field

`endif

//--- source/cnn_pkg.sv
`include "cnn_defs.svh"

package cnn_pkg;

  typedef logic signed [`CNN_DWIDTH-1:0] data_t;
  typedef logic signed [`CNN_AWIDTH-1:0] acc_t;

  // parameter slot, 0..8 weights, 9 bias
  typedef logic [$clog2(`CNN_NPARAM)-1:0] pidx_t;

  typedef logic [$clog2(`CNN_POOL)-1:0] phase_t;
  typedef logic [`CNN_QWIDTH-1:0]       qbits_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    RUN
  } ctrl_state_t;

endpackage

//--- source/cnn_ctrl.sv
`include "cnn_defs.svh"

module cnn_ctrl
  import cnn_pkg::*;
  ( input         clk
  , input         arst_n
  , input         load_start
  , input         param_valid
  , input         window_valid
  , input  pidx_t param_idx
  , output logic  weight_we
  , output logic  bias_we
  , output logic  idx_inc
  , output logic  idx_clr
  , output logic  window_accept
  , output logic  busy
  );

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        param_take;
  logic        last_param;

  // a strobe together with load_start is dropped
  assign param_take = (state == LOAD) && param_valid && !load_start;
  assign last_param = param_idx == pidx_t'(`CNN_NPARAM - 1);

  assign weight_we = param_take && !last_param;
  assign bias_we   = param_take && last_param; // bias is the tenth word
  assign idx_inc   = weight_we || bias_we;
  assign idx_clr   = load_start;

  assign window_accept = (state == RUN) && window_valid && !load_start;
  assign busy          = state == LOAD;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: state_next = IDLE;
      LOAD: if (bias_we) state_next = RUN;
      RUN:  state_next = RUN;
      default: state_next = IDLE;
    endcase
    if (load_start)
      state_next = LOAD; // restart from anywhere
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      state <= IDLE;
    else
      state <= state_next;
  end

  a_one_write: assert property (@(posedge clk) disable iff (!arst_n)
    !(weight_we && bias_we));

endmodule

//--- source/cnn_counter.sv
`include "cnn_defs.svh"

module cnn_counter
  import cnn_pkg::*;
  ( input          clk
  , input          arst_n
  , input          idx_inc
  , input          idx_clr
  , input          act_valid
  , input          pool_en
  , output pidx_t  param_idx
  , output phase_t pool_phase
  , output logic   group_end
  );

  logic idx_last;

  assign idx_last  = param_idx == pidx_t'(`CNN_NPARAM - 1);
  assign group_end = act_valid && pool_en && (pool_phase == phase_t'(`CNN_POOL - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      param_idx  <= '0;
      pool_phase <= '0;
    end else begin
      if (idx_clr)
        param_idx <= '0;
      else if (idx_inc)
        param_idx <= idx_last ? '0 : param_idx + 1'b1; // wrap after bias
      if (idx_clr)
        pool_phase <= '0;
      else if (act_valid && pool_en)
        pool_phase <= group_end ? '0 : pool_phase + 1'b1;
    end
  end

  a_idx_range: assert property (@(posedge clk) disable iff (!arst_n)
    param_idx < pidx_t'(`CNN_NPARAM));

endmodule

//--- source/conv_mac.sv
`include "cnn_defs.svh"

module conv_mac
  import cnn_pkg::*;
  ( input         clk
  , input         arst_n
  , input         weight_we
  , input  pidx_t param_idx
  , input  data_t param_data
  , input         window_accept
  , input  data_t pixel [`CNN_KERN*`CNN_KERN]
  , output acc_t  acc
  , output logic  acc_valid
  );

  localparam int ntap = `CNN_KERN * `CNN_KERN;

  data_t weight [ntap];
  acc_t  sum;

  // weight file, taps in row-major order
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ntap; i++)
        weight[i] <= '0;
    end else if (weight_we) begin
      weight[param_idx] <= param_data;
    end
  end

  always_comb begin
    sum = '0;
    for (int i = 0; i < ntap; i++)
      sum = sum + acc_t'(pixel[i]) * acc_t'(weight[i]); // signed, full width
  end

  always_ff @(posedge clk) begin
    if (window_accept)
      acc <= sum;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      acc_valid <= 1'b0;
    else
      acc_valid <= window_accept;
  end

  // one window in, one accumulator out next cycle
  a_acc_follow: assert property (@(posedge clk) disable iff (!arst_n)
    window_accept |=> acc_valid);

endmodule

//--- source/bias_relu.sv
`include "cnn_defs.svh"

module bias_relu
  import cnn_pkg::*;
  ( input          clk
  , input          arst_n
  , input          bias_we
  , input  data_t  param_data
  , input  acc_t   acc
  , input          acc_valid
  , input  qbits_t qbits
  , input          bias_en
  , input          relu_en
  , output data_t  act
  , output logic   act_valid
  );

  localparam data_t data_max = {1'b0, {(`CNN_DWIDTH-1){1'b1}}};
  localparam data_t data_min = {1'b1, {(`CNN_DWIDTH-1){1'b0}}};

  data_t bias;
  acc_t  biased;
  acc_t  shifted;
  data_t sat;
  data_t act_next;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      bias <= '0;
    else if (bias_we)
      bias <= param_data;
  end

  always_comb begin
    biased  = bias_en ? acc + acc_t'(bias) : acc;
    shifted = biased >>> qbits; // requantise
    if (shifted > acc_t'(data_max))
      sat = data_max;
    else if (shifted < acc_t'(data_min))
      sat = data_min;
    else
      sat = data_t'(shifted);
    act_next = (relu_en && sat < 0) ? '0 : sat;
  end

  always_ff @(posedge clk) begin
    if (acc_valid)
      act <= act_next;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      act_valid <= 1'b0;
    else
      act_valid <= acc_valid;
  end

endmodule

//--- source/max_pool.sv
`include "cnn_defs.svh"

module max_pool
  import cnn_pkg::*;
  ( input          clk
  , input          arst_n
  , input  data_t  act
  , input          act_valid
  , input          pool_en
  , input  phase_t pool_phase
  , input          group_end
  , output data_t  result
  , output logic   result_valid
  );

  data_t run_max;
  data_t cand;
  logic  emit;

  // phase 0 starts a fresh group
  assign cand = (pool_phase == '0 || act > run_max) ? act : run_max;

  assign emit = pool_en ? group_end : act_valid;

  always_ff @(posedge clk) begin
    if (act_valid)
      run_max <= cand;
  end

  always_ff @(posedge clk) begin
    if (emit)
      result <= pool_en ? cand : act;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      result_valid <= 1'b0;
    else
      result_valid <= emit;
  end

endmodule

//--- source/cnn_core.sv
`include "cnn_defs.svh"

module cnn_core
  import cnn_pkg::*;
  ( input          clk
  , input          arst_n
  , input          load_start
  , input          param_valid
  , input  data_t  param_data
  , input          window_valid
  , input  data_t  pixel [`CNN_KERN*`CNN_KERN]
  , input  qbits_t qbits
  , input          bias_en
  , input          relu_en
  , input          pool_en
  , output         result_valid
  , output data_t  result
  , output         busy
  );

  logic   weight_we;
  logic   bias_we;
  logic   idx_inc;
  logic   idx_clr;
  logic   window_accept;
  pidx_t  param_idx;
  phase_t pool_phase;
  logic   group_end;
  acc_t   acc;
  logic   acc_valid;
  data_t  act;
  logic   act_valid;

  cnn_ctrl ctrl (
    .param_idx     (param_idx),
    .window_accept (window_accept),
    .*
  );

  cnn_counter counter (
    .act_valid  (act_valid),
    .group_end  (group_end),
    .*
  );

  conv_mac conv (
    .window_accept (window_accept),
    .acc           (acc),
    .acc_valid     (acc_valid),
    .*
  );

  bias_relu bias (
    .acc        (acc),
    .act        (act),
    .act_valid  (act_valid),
    .*
  );

  max_pool pool (
    .act        (act),
    .pool_phase (pool_phase),
    .result     (result),
    .*
  );

endmodule

//--- test/cnn_checker.sv
`include "cnn_defs.svh"

module cnn_checker
  import cnn_pkg::*;
  ( input         clk
  , input         arst_n
  , input         load_start
  , input         param_valid
  , input  data_t param_data
  , input         window_valid
  , input  data_t pixel [`CNN_KERN*`CNN_KERN]
  , input qbits_t qbits
  , input         bias_en
  , input         relu_en
  , input         pool_en
  , input         result_valid
  , input  data_t result
  , input         busy
  , input  int    test_id
  , output int    errors
  , output int    checks
  , output int    pending
  );

  localparam longint sat_max = (longint'(1) <<< (`CNN_DWIDTH - 1)) - 1;
  localparam longint sat_min = -(longint'(1) <<< (`CNN_DWIDTH - 1));

  ctrl_state_t st;
  int          idx;
  int          w_model [`CNN_KERN*`CNN_KERN];
  int          bias_model;
  int          exp_q [$];
  int          grp [$];
  int          want;
  int          got;
  int          grp_max;

  function automatic string test_name(input int id);
    case (id)
      1: test_name = "plain_conv";
      2: test_name = "bias_requant";
      3: test_name = "relu";
      4: test_name = "pooling";
      5: test_name = "load_rules";
      6: test_name = "reload";
      default: test_name = "setup";
    endcase
  endfunction

  // products, bias, shift, saturate, relu
  function automatic int ref_act();
    longint sum;
    longint v;
    sum = 0;
    for (int i = 0; i < `CNN_KERN*`CNN_KERN; i++)
      sum = sum + longint'(pixel[i]) * longint'(w_model[i]);
    v = bias_en ? sum + longint'(bias_model) : sum;
    v = v >>> qbits;
    if (v > sat_max)
      v = sat_max;
    else if (v < sat_min)
      v = sat_min;
    if (relu_en && v < 0)
      v = 0;
    return int'(v);
  endfunction

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      st = IDLE;
      idx = 0;
      bias_model = 0;
      for (int i = 0; i < `CNN_KERN*`CNN_KERN; i++)
        w_model[i] = 0;
      exp_q.delete();
      grp.delete();
      errors = 0;
      checks = 0;
    end else begin
      if (busy !== (st == LOAD)) begin
        $display("busy does not match the load state in test %0s", test_name(test_id));
        errors++;
      end
      if (result_valid) begin
        got = result;
        if (exp_q.size() == 0) begin
          $display("result %0d arrived with no expected value in test %0s",
                   got, test_name(test_id));
          errors++;
        end else begin
          want = exp_q.pop_front();
          checks++;
          if (got !== want) begin
            $display("Fail %0s expected %0d actual %0d", test_name(test_id), want, got);
            errors++;
          end
          if (relu_en && got < 0) begin
            $display("negative result %0d with relu on", got);
            errors++;
          end
        end
      end
      if (load_start) begin
        st = LOAD;
        idx = 0;
        grp.delete(); // pool phase restarts
      end else if (st == LOAD && param_valid) begin
        if (idx < `CNN_NPARAM - 1) begin
          w_model[idx] = param_data;
          idx++;
        end else begin
          bias_model = param_data;
          idx = 0;
          st = RUN;
        end
      end else if (st == RUN && window_valid) begin
        if (pool_en) begin
          grp.push_back(ref_act());
          if (grp.size() == `CNN_POOL) begin
            grp_max = grp[0];
            foreach (grp[i])
              if (grp[i] > grp_max) grp_max = grp[i];
            exp_q.push_back(grp_max);
            grp.delete();
          end
        end else begin
          exp_q.push_back(ref_act());
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

//--- test/tb_cnn_core.sv
`include "cnn_defs.svh"

module tb_cnn_core
  import cnn_pkg::*;
  ();

  localparam int max_cycles = 2000; // tests need about 500

  logic   clk;
  logic   arst_n;
  logic   load_start;
  logic   param_valid;
  data_t  param_data;
  logic   window_valid;
  data_t  pixel [`CNN_KERN*`CNN_KERN];
  qbits_t qbits;
  logic   bias_en;
  logic   relu_en;
  logic   pool_en;
  logic   result_valid;
  data_t  result;
  logic   busy;
  int     test_id;
  int     errors;
  int     checks;
  int     pending;
  int     cycles;
  int     total;

  cnn_core DUT (.*);

  cnn_checker chk (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run stopped after %0d cycles, %0d errors so far", cycles, errors);
      $display("Something failed");
      $finish;
    end
  end

  function automatic int rand_val(input int r);
    rand_val = int'($urandom % (2 * r + 1)) - r;
  endfunction

  task automatic set_config(input int id, input int q, input logic b, input logic r,
                            input logic p);
    @(posedge clk);
    test_id <= id;
    qbits   <= qbits_t'(q);
    bias_en <= b;
    relu_en <= r;
    pool_en <= p;
  endtask

  // nine weights then bias, optionally with windows thrown in
  task automatic load_params(input int wr, input int woff, input int br, input logic win);
    @(posedge clk);
    load_start <= 1'b1;
    for (int i = 0; i < `CNN_NPARAM; i++) begin
      @(posedge clk);
      load_start   <= 1'b0;
      param_valid  <= 1'b1;
      param_data   <= (i < `CNN_NPARAM - 1) ? data_t'(rand_val(wr) + woff)
                                            : data_t'(rand_val(br));
      window_valid <= win;
    end
    @(posedge clk);
    param_valid  <= 1'b0;
    window_valid <= 1'b0;
  endtask

  task automatic stray_params(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      param_valid <= 1'b1;
      param_data  <= data_t'(rand_val(30000));
    end
    @(posedge clk);
    param_valid <= 1'b0;
  endtask

  task automatic send_windows(input int n, input int r, input int off);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      window_valid <= 1'b1;
      for (int i = 0; i < `CNN_KERN*`CNN_KERN; i++)
        pixel[i] <= data_t'(rand_val(r) + off);
    end
    @(posedge clk);
    window_valid <= 1'b0;
  endtask

  task automatic drain;
    @(negedge clk);
    while (pending != 0)
      @(negedge clk);
    repeat (4) @(posedge clk); // let partial pool groups settle
  endtask

  initial begin
    void'($urandom(30));
    clk = 1'b0;
    arst_n = 1'b0;
    load_start = 1'b0;
    param_valid = 1'b0;
    param_data = '0;
    window_valid = 1'b0;
    for (int i = 0; i < `CNN_KERN*`CNN_KERN; i++)
      pixel[i] = '0;
    qbits = '0;
    bias_en = 1'b0;
    relu_en = 1'b0;
    pool_en = 1'b0;
    test_id = 0;
    cycles = 0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    set_config(1, 0, 1'b0, 1'b0, 1'b0);
    load_params(100, 0, 100, 1'b0);
    send_windows(60, 100, 0);
    drain();

    set_config(2, 0, 1'b1, 1'b0, 1'b0);
    load_params(2000, 0, 30000, 1'b0); // big enough to saturate
    for (int q = 0; q <= 12; q += 4) begin
      set_config(2, q, 1'b1, 1'b0, 1'b0);
      send_windows(10, 2000, 0);
      drain();
    end

    set_config(3, 2, 1'b1, 1'b1, 1'b0);
    load_params(20, 20, 50, 1'b0); // positive weights, mostly negative pixels
    send_windows(30, 60, -40);
    drain();

    set_config(4, 0, 1'b1, 1'b0, 1'b1);
    load_params(50, 0, 200, 1'b0);
    send_windows(40, 100, 0);
    drain();

    set_config(5, 0, 1'b0, 1'b0, 1'b0);
    load_params(50, 0, 0, 1'b1);
    stray_params(5);
    send_windows(20, 100, 0);
    drain();

    set_config(6, 0, 1'b1, 1'b0, 1'b1);
    load_params(50, 0, 100, 1'b0);
    send_windows(6, 100, 0); // leaves half a group behind
    drain();
    load_params(80, 0, 300, 1'b0);
    send_windows(8, 100, 0);
    drain();

    total = errors;
    if (pending != 0) begin
      $display("%0d expected results never arrived", pending);
      total = total + 1;
    end
    $display("%0d errors in %0d checked results", total, checks);
    if (total == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- src.f
+incdir+source
source/cnn_pkg.sv
source/cnn_ctrl.sv
source/cnn_counter.sv
source/conv_mac.sv
source/bias_relu.sv
source/max_pool.sv
source/cnn_core.sv
test/cnn_checker.sv
test/tb_cnn_core.sv
